// File: include/corr_macros.svh
// ********************************************************************
// correlator sizing macros.
// fifo depth, packet length and the largest accepted exponents.
// ********************************************************************

`ifndef CORR_MACROS_SVH
`define CORR_MACROS_SVH

// packet fifo, sized in bytes.
`define CORR_FIFO_DEPTH 16
`define CORR_FIFO_PTR_W 4
`define CORR_FIFO_CNT_W 5

// one packet is count_x, count_y, count_xy, sequence.
`define CORR_PKT_LEN 4

// ********************************************************************
// exponent limits, larger writes are clamped.
// ********************************************************************
`define CORR_MAX_WIN_EXP 8
`define CORR_MAX_PER_EXP 7

`endif

// File: run.sh
#!/usr/bin/env bash
# compile and run the correlator testbench with verilator.
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module corr_tb -Mdir obj_dir &&
  ./obj_dir/Vcorr_tb ||
  { echo "simulation run returned a failing status"; exit 1; }

// File: sim.f
+incdir+include
src/corr_pkg.sv
src/pkt_fifo.sv
src/reg_frontend.sv
src/corr_window_acc.sv
src/led_pwm.sv
src/corr_top.sv
verif/corr_sva.sv
verif/corr_tb.sv

// File: src/corr_pkg.sv
// ********************************************************************
// correlator shared types.
// register map, byte, exponent and count types.
// ********************************************************************

`default_nettype none

package corr_pkg;

  typedef logic [7:0] corr_byte_t;
  typedef logic [3:0] corr_exp_t;
  typedef logic [8:0] corr_cnt_t; // 2^8 samples need the ninth bit.

  typedef enum logic [1:0] {
    LED_SRC_X,
    LED_SRC_Y,
    LED_SRC_XY
  } corr_led_src_t;

  typedef enum logic [2:0] {
    REG_WIN_EXP   = 3'd0,
    REG_PER_EXP   = 3'd1,
    REG_LED_SRC   = 3'd2,
    REG_FIFO_DATA = 3'd3,
    REG_FIFO_STAT = 3'd4,
    REG_FLUSH     = 3'd5
  } corr_reg_addr_t;

endpackage

`default_nettype wire

// File: src/corr_top.sv
// ********************************************************************
// coincidence correlator top.
// register front end, window accumulator, packet fifo and led pwm.
// ********************************************************************

`timescale 1ns/1ps
`default_nettype none
`include "corr_macros.svh"

module corr_top import corr_pkg::*; (
  input  logic       i_clk,
  input  logic       i_arst_n,
  input  logic       i_cg,
  input  logic       i_x,
  input  logic       i_y,
  input  corr_byte_t i_up_data,
  input  logic       i_up_valid,
  output logic       o_up_ready,
  output corr_byte_t o_dn_data,
  output logic       o_dn_valid,
  input  logic       i_dn_ready,
  output logic       o_led
);

  corr_exp_t                   win_exp;
  corr_exp_t                   per_exp;
  corr_led_src_t               led_src;
  logic                        cfg_restart;
  logic                        fifo_pop;
  logic                        fifo_flush;
  logic                        fifo_push;
  logic                        fifo_empty;
  logic                        fifo_room_pkt;
  logic [`CORR_FIFO_CNT_W-1:0] fifo_count;
  corr_byte_t                  fifo_head;
  corr_byte_t                  fifo_wdata;
  corr_byte_t                  last_x, last_y, last_xy;
  logic                        win_done;

  reg_frontend u_frontend (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_up_data     (i_up_data),
    .i_up_valid    (i_up_valid),
    .o_up_ready    (o_up_ready),
    .o_dn_data     (o_dn_data),
    .o_dn_valid    (o_dn_valid),
    .i_dn_ready    (i_dn_ready),
    .o_win_exp     (win_exp),
    .o_per_exp     (per_exp),
    .o_led_src     (led_src),
    .o_cfg_restart (cfg_restart),
    .o_fifo_pop    (fifo_pop),
    .o_fifo_flush  (fifo_flush),
    .i_fifo_head   (fifo_head),
    .i_fifo_empty  (fifo_empty),
    .i_fifo_count  (fifo_count)
  );

  corr_window_acc u_acc (
    .i_clk           (i_clk),
    .i_arst_n        (i_arst_n),
    .i_cg            (i_cg),
    .i_x             (i_x),
    .i_y             (i_y),
    .i_win_exp       (win_exp),
    .i_per_exp       (per_exp),
    .i_cfg_restart   (cfg_restart),
    .i_fifo_room_pkt (fifo_room_pkt),
    .o_fifo_push     (fifo_push),
    .o_fifo_wdata    (fifo_wdata),
    .o_last_x        (last_x),
    .o_last_y        (last_y),
    .o_last_xy       (last_xy),
    .o_win_done      (win_done)
  );

  pkt_fifo u_fifo (
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .i_push     (fifo_push),
    .i_wdata    (fifo_wdata),
    .i_pop      (fifo_pop),
    .i_flush    (fifo_flush),
    .o_head     (fifo_head),
    .o_empty    (fifo_empty),
    .o_count    (fifo_count),
    .o_room_pkt (fifo_room_pkt)
  );

  led_pwm u_pwm (
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .i_led_src  (led_src),
    .i_last_x   (last_x),
    .i_last_y   (last_y),
    .i_last_xy  (last_xy),
    .i_win_done (win_done),
    .o_led      (o_led)
  );

endmodule

`default_nettype wire

// File: src/corr_window_acc.sv
// ********************************************************************
// coincidence window accumulator.
// samples x and y at a programmable period, counts x, y and x&y
// per window and serializes each finished window as a packet.
// ********************************************************************

`timescale 1ns/1ps
`default_nettype none
`include "corr_macros.svh"

module corr_window_acc import corr_pkg::*; (
  input  logic       i_clk,
  input  logic       i_arst_n,
  input  logic       i_cg,
  input  logic       i_x,
  input  logic       i_y,
  input  corr_exp_t  i_win_exp,
  input  corr_exp_t  i_per_exp,
  input  logic       i_cfg_restart,
  input  logic       i_fifo_room_pkt,
  output logic       o_fifo_push,
  output corr_byte_t o_fifo_wdata,
  output corr_byte_t o_last_x,
  output corr_byte_t o_last_y,
  output corr_byte_t o_last_xy,
  output logic       o_win_done
);

  logic [`CORR_MAX_PER_EXP-1:0] per_cnt;
  logic [`CORR_MAX_PER_EXP-1:0] per_mask;
  logic [`CORR_MAX_WIN_EXP-1:0] smp_cnt;
  logic [`CORR_MAX_WIN_EXP-1:0] win_mask;
  corr_cnt_t                    cnt_x, cnt_y, cnt_xy;
  corr_cnt_t                    nxt_x, nxt_y, nxt_xy;
  corr_byte_t                   seq;
  corr_byte_t                   pkt_q [`CORR_PKT_LEN];
  logic [1:0]                   pkt_idx;
  logic                         pkt_busy;
  logic                         pkt_last;
  logic                         pkt_take;
  logic                         sample_en;
  logic                         win_end;

  function automatic corr_byte_t sat8(input corr_cnt_t c);
    sat8 = c[8] ? 8'hff : c[7:0];
  endfunction

  assign per_mask  = ~({`CORR_MAX_PER_EXP{1'b1}} << i_per_exp);
  assign win_mask  = ~({`CORR_MAX_WIN_EXP{1'b1}} << i_win_exp);
  assign sample_en = i_cg && (per_cnt == '0);
  assign win_end   = sample_en && (smp_cnt == win_mask);

  // counts including the sample taken this cycle.
  assign nxt_x  = cnt_x + corr_cnt_t'(i_x);
  assign nxt_y  = cnt_y + corr_cnt_t'(i_y);
  assign nxt_xy = cnt_xy + corr_cnt_t'(i_x & i_y);

  // a new packet may follow directly behind the last byte of the previous one.
  // otherwise it is dropped like a packet without fifo room.
  assign pkt_last = pkt_busy && (pkt_idx == 2'(`CORR_PKT_LEN - 1));
  assign pkt_take = win_end && i_fifo_room_pkt && (!pkt_busy || pkt_last);

  assign o_fifo_push  = pkt_busy;
  assign o_fifo_wdata = pkt_q[pkt_idx];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      per_cnt    <= '0;
      smp_cnt    <= '0;
      cnt_x      <= '0;
      cnt_y      <= '0;
      cnt_xy     <= '0;
      seq        <= '0;
      pkt_busy   <= 1'b0;
      pkt_idx    <= '0;
      o_win_done <= 1'b0;
    end else if (i_cfg_restart) begin
      per_cnt    <= '0;
      smp_cnt    <= '0;
      cnt_x      <= '0;
      cnt_y      <= '0;
      cnt_xy     <= '0;
      seq        <= '0;
      pkt_busy   <= 1'b0; // unsent bytes are abandoned.
      pkt_idx    <= '0;
      o_win_done <= 1'b0;
    end else begin
      o_win_done <= win_end;
      if (i_cg) per_cnt <= (per_cnt == per_mask) ? '0 : per_cnt + 1'b1;
      if (win_end) begin
        smp_cnt <= '0;
        cnt_x   <= '0;
        cnt_y   <= '0;
        cnt_xy  <= '0;
        seq     <= seq + 1'b1; // advances on dropped packets too.
      end else if (sample_en) begin
        smp_cnt <= smp_cnt + 1'b1;
        cnt_x   <= nxt_x;
        cnt_y   <= nxt_y;
        cnt_xy  <= nxt_xy;
      end
      if (pkt_take) begin
        pkt_busy <= 1'b1;
        pkt_idx  <= '0;
      end else if (pkt_busy) begin
        pkt_idx <= pkt_idx + 1'b1;
        if (pkt_last) pkt_busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (pkt_take) begin
      pkt_q[0] <= sat8(nxt_x);
      pkt_q[1] <= sat8(nxt_y);
      pkt_q[2] <= sat8(nxt_xy);
      pkt_q[3] <= seq;
    end
    if (win_end) begin
      o_last_x  <= sat8(nxt_x);
      o_last_y  <= sat8(nxt_y);
      o_last_xy <= sat8(nxt_xy);
    end
  end

endmodule

`default_nettype wire

// File: src/led_pwm.sv
// ********************************************************************
// led pwm.
// shows one count of the last finished window as a duty cycle.
// ********************************************************************

`timescale 1ns/1ps
`default_nettype none

module led_pwm import corr_pkg::*; (
  input  logic          i_clk,
  input  logic          i_arst_n,
  input  corr_led_src_t i_led_src,
  input  corr_byte_t    i_last_x,
  input  corr_byte_t    i_last_y,
  input  corr_byte_t    i_last_xy,
  input  logic          i_win_done,
  output logic          o_led
);

  corr_byte_t metric_q;
  corr_byte_t pwm_cnt;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      metric_q <= '0; // dark until the first window.
      pwm_cnt  <= '0;
    end else begin
      pwm_cnt <= pwm_cnt + 1'b1;
      if (i_win_done) begin
        case (i_led_src)
          LED_SRC_X:  metric_q <= i_last_x;
          LED_SRC_Y:  metric_q <= i_last_y;
          LED_SRC_XY: metric_q <= i_last_xy;
          default:    metric_q <= '0;
        endcase
      end
    end
  end

  assign o_led = (pwm_cnt < metric_q);

endmodule

`default_nettype wire

// File: src/pkt_fifo.sv
// ********************************************************************
// packet byte fifo.
// circular buffer with fall-through head and a whole-packet room flag.
// ********************************************************************

`timescale 1ns/1ps
`default_nettype none
`include "corr_macros.svh"

module pkt_fifo import corr_pkg::*; (
  input  logic                        i_clk,
  input  logic                        i_arst_n,
  input  logic                        i_push,
  input  corr_byte_t                  i_wdata,
  input  logic                        i_pop,
  input  logic                        i_flush,
  output corr_byte_t                  o_head,
  output logic                        o_empty,
  output logic [`CORR_FIFO_CNT_W-1:0] o_count,
  output logic                        o_room_pkt
);

  corr_byte_t                   mem [`CORR_FIFO_DEPTH];
  logic [`CORR_FIFO_PTR_W-1:0]  wr_ptr;
  logic [`CORR_FIFO_PTR_W-1:0]  rd_ptr;
  logic                         do_push;
  logic                         do_pop;

  assign o_empty = (o_count == '0);
  assign do_push = i_push && (o_count != `CORR_FIFO_CNT_W'(`CORR_FIFO_DEPTH));
  assign do_pop  = i_pop && !o_empty;
  assign o_head  = mem[rd_ptr];

  // the byte being written this cycle already counts as taken.
  assign o_room_pkt = (int'(o_count) + int'(i_push) + `CORR_PKT_LEN) <= `CORR_FIFO_DEPTH;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      o_count <= '0;
    end else if (i_flush) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      o_count <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      o_count <= o_count + do_push - do_pop;
    end
  end

  always_ff @(posedge i_clk) begin
    if (do_push && !i_flush) mem[wr_ptr] <= i_wdata;
  end

endmodule

`default_nettype wire

// File: src/reg_frontend.sv
// ********************************************************************
// byte-pipe register front end.
// decodes host command bytes, holds the configuration and
// answers reads on the downstream pipe.
// ********************************************************************

`timescale 1ns/1ps
`default_nettype none
`include "corr_macros.svh"

module reg_frontend import corr_pkg::*; (
  input  logic                        i_clk,
  input  logic                        i_arst_n,
  input  corr_byte_t                  i_up_data,
  input  logic                        i_up_valid,
  output logic                        o_up_ready,
  output corr_byte_t                  o_dn_data,
  output logic                        o_dn_valid,
  input  logic                        i_dn_ready,
  output corr_exp_t                   o_win_exp,
  output corr_exp_t                   o_per_exp,
  output corr_led_src_t               o_led_src,
  output logic                        o_cfg_restart,
  output logic                        o_fifo_pop,
  output logic                        o_fifo_flush,
  input  corr_byte_t                  i_fifo_head,
  input  logic                        i_fifo_empty,
  input  logic [`CORR_FIFO_CNT_W-1:0] i_fifo_count
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_DATA,
    ST_RESP
  } fe_state_t;

  fe_state_t      state_q;
  corr_reg_addr_t addr_q;
  corr_reg_addr_t cmd_addr;
  corr_byte_t     resp_q;
  corr_byte_t     rd_data;
  logic           up_fire;
  logic           rd_fire;
  logic           wr_fire;

  function automatic corr_exp_t clamp_exp(input corr_byte_t v, input corr_byte_t lim);
    clamp_exp = (v > lim) ? corr_exp_t'(lim) : corr_exp_t'(v);
  endfunction

  assign o_up_ready = (state_q != ST_RESP);
  assign up_fire    = i_up_valid && o_up_ready;
  assign cmd_addr   = corr_reg_addr_t'(i_up_data[2:0]);
  assign rd_fire    = up_fire && (state_q == ST_IDLE) && !i_up_data[7];
  assign wr_fire    = up_fire && (state_q == ST_DATA);

  // pop only together with the capture of the head byte.
  assign o_fifo_pop    = rd_fire && (cmd_addr == REG_FIFO_DATA) && !i_fifo_empty;
  assign o_fifo_flush  = wr_fire && (addr_q == REG_FLUSH);
  assign o_cfg_restart = wr_fire && ((addr_q == REG_WIN_EXP) || (addr_q == REG_PER_EXP));

  assign o_dn_valid = (state_q == ST_RESP);
  assign o_dn_data  = resp_q; // held until the transfer.

  always_comb begin
    case (cmd_addr)
      REG_WIN_EXP:   rd_data = corr_byte_t'(o_win_exp);
      REG_PER_EXP:   rd_data = corr_byte_t'(o_per_exp);
      REG_LED_SRC:   rd_data = corr_byte_t'(o_led_src);
      REG_FIFO_DATA: rd_data = i_fifo_empty ? '0 : i_fifo_head;
      REG_FIFO_STAT: rd_data = {i_fifo_empty, 2'b00, i_fifo_count};
      default:       rd_data = '0;
    endcase
  end

  // ********************************************************************
  // command fsm and configuration registers.
  // ********************************************************************
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q   <= ST_IDLE;
      addr_q    <= REG_WIN_EXP;
      o_win_exp <= '0;
      o_per_exp <= '0;
      o_led_src <= LED_SRC_X;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (up_fire) begin
            if (i_up_data[7]) begin // write, data byte follows.
              addr_q  <= cmd_addr;
              state_q <= ST_DATA;
            end else begin
              state_q <= ST_RESP;
            end
          end
        end
        ST_DATA: begin
          if (up_fire) begin
            state_q <= ST_IDLE;
            case (addr_q)
              REG_WIN_EXP: o_win_exp <= clamp_exp(i_up_data, 8'(`CORR_MAX_WIN_EXP));
              REG_PER_EXP: o_per_exp <= clamp_exp(i_up_data, 8'(`CORR_MAX_PER_EXP));
              REG_LED_SRC: o_led_src <= corr_led_src_t'(i_up_data[1:0]);
              default:     ; // read-only or flush.
            endcase
          end
        end
        ST_RESP: begin
          if (i_dn_ready) state_q <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (rd_fire) resp_q <= rd_data;
  end

endmodule

`default_nettype wire

// File: verif/corr_sva.sv
// ********************************************************************
// byte-pipe and fifo checks.
// bound into the register front end and the packet fifo.
// ********************************************************************

`timescale 1ns/1ps
`default_nettype none
`include "corr_macros.svh"

module corr_sva import corr_pkg::*; (
  input logic                        i_clk,
  input logic                        i_arst_n,
  input logic                        i_dn_valid,
  input logic                        i_dn_ready,
  input corr_byte_t                  i_dn_data,
  input logic [`CORR_FIFO_CNT_W-1:0] i_count,
  input logic                        i_push
);

  // a stalled response keeps its byte until the transfer.
  a_dn_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (i_dn_valid && !i_dn_ready) |=> (i_dn_valid && $stable(i_dn_data)))
    else $error("downstream byte dropped or changed before its transfer");

  a_fill_max: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_count <= `CORR_FIFO_CNT_W'(`CORR_FIFO_DEPTH))
    else $error("fifo fill count above its depth");

  a_no_push_full: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    !(i_push && (i_count == `CORR_FIFO_CNT_W'(`CORR_FIFO_DEPTH))))
    else $error("byte pushed into a full fifo");

endmodule

bind reg_frontend corr_sva u_sva (
  .i_clk      (i_clk),
  .i_arst_n   (i_arst_n),
  .i_dn_valid (o_dn_valid),
  .i_dn_ready (i_dn_ready),
  .i_dn_data  (o_dn_data),
  .i_count    (i_fifo_count),
  .i_push     (1'b0)
);

bind pkt_fifo corr_sva u_sva (
  .i_clk      (i_clk),
  .i_arst_n   (i_arst_n),
  .i_dn_valid (1'b0),
  .i_dn_ready (1'b1),
  .i_dn_data  (8'h00),
  .i_count    (o_count),
  .i_push     (i_push)
);

`default_nettype wire

// File: verif/corr_tb.sv
// ********************************************************************
// correlator testbench.
// drives the host byte pipe and the x, y and cg levels, and checks
// register reads, packets and the led duty cycle against a model.
// ********************************************************************

`timescale 1ns/1ps
`default_nettype none
`include "corr_macros.svh"

module corr_tb import corr_pkg::*; ();

  localparam int HS_LIMIT  = 64;   // cycles allowed for one handshake.
  localparam int RUN_LIMIT = 4096; // cycles allowed for one run of windows.
  localparam int NUM_ROWS  = 5;

  typedef struct packed {
    logic [3:0] win_exp;
    logic [3:0] per_exp;
    logic [1:0] led_src;
    logic [7:0] n_win;
    logic       cg_drop;
    logic       stall;
    logic       overflow;
    logic       x_high;
  } row_t;

  logic        i_clk;
  logic        i_arst_n;
  logic        i_cg;
  logic        i_x;
  logic        i_y;
  corr_byte_t  i_up_data;
  logic        i_up_valid;
  logic        o_up_ready;
  corr_byte_t  o_dn_data;
  logic        o_dn_valid;
  logic        i_dn_ready;
  logic        o_led;

  logic [31:0] lfsr_q;
  row_t        rows [NUM_ROWS];
  logic        stall_on;
  logic        cg_drop;
  logic        x_high;
  corr_byte_t  exp_q [$]; // bytes the fifo should hold.
  int          cfg_win, cfg_per;
  int          m_per, m_smp, m_cx, m_cy, m_cxy, m_seq;
  int          win_count;
  corr_byte_t  last_x, last_y, last_xy;

  corr_top dut0 (
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .i_cg       (i_cg),
    .i_x        (i_x),
    .i_y        (i_y),
    .i_up_data  (i_up_data),
    .i_up_valid (i_up_valid),
    .o_up_ready (o_up_ready),
    .o_dn_data  (o_dn_data),
    .o_dn_valid (o_dn_valid),
    .i_dn_ready (i_dn_ready),
    .o_led      (o_led)
  );

  always #10 i_clk = ~i_clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32+x^22+x^2+x+1.
  endfunction

  task automatic rand_bit(output logic b);
    lfsr_q = lfsr_next(lfsr_q);
    b = lfsr_q[0];
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else
      abort_run($sformatf("Error at time %0t: %s is 0x%0h, expected 0x%0h",
                          $time, name, got, exp));
  endtask

  // ********************************************************************
  // host byte pipe.
  // ********************************************************************
  task automatic send_byte(input corr_byte_t b);
    logic done;
    int   n;
    done = 1'b0;
    @(posedge i_clk);
    i_up_data  <= b;
    i_up_valid <= 1'b1;
    for (n = 0; n < HS_LIMIT && !done; n++) begin
      @(negedge i_clk);
      done = o_up_ready; // accepted at the coming edge.
      @(posedge i_clk);
    end
    i_up_valid <= 1'b0;
    if (!done) abort_run("timeout, the upstream pipe never accepted a byte");
  endtask

  task automatic recv_byte(output corr_byte_t b);
    logic done;
    logic r;
    int   n;
    done = 1'b0;
    b    = '0;
    for (n = 0; n < HS_LIMIT && !done; n++) begin
      @(negedge i_clk);
      if (o_dn_valid && i_dn_ready) begin
        b    = o_dn_data;
        done = 1'b1;
      end
      @(posedge i_clk);
      rand_bit(r);
      i_dn_ready <= stall_on ? r : 1'b1;
    end
    if (!done) abort_run("timeout, no response byte came out of the downstream pipe");
  endtask

  task automatic write_reg(input logic [2:0] addr, input corr_byte_t data);
    send_byte({5'b10000, addr});
    send_byte(data);
  endtask

  task automatic read_reg(input logic [2:0] addr, output corr_byte_t data);
    send_byte({5'b00000, addr});
    recv_byte(data);
  endtask

  task automatic read_fifo_byte();
    corr_byte_t got;
    corr_byte_t exp;
    exp = 8'h00; // an empty fifo answers zero.
    if (exp_q.size() > 0) exp = exp_q.pop_front();
    read_reg(REG_FIFO_DATA, got);
    check_value("o_dn_data (fifo data)", got, exp);
  endtask

  task automatic drain_packets(input int n_pkt);
    int n;
    for (n = 0; n < n_pkt * `CORR_PKT_LEN; n++) read_fifo_byte();
  endtask

  task automatic check_status();
    corr_byte_t got;
    read_reg(REG_FIFO_STAT, got);
    assert (got[4:0] <= `CORR_FIFO_DEPTH && got[1:0] == 2'b00) else
      abort_run("fifo fill count is not whole packets or is above the depth");
    check_value("o_dn_data (fifo status)", got,
                {exp_q.size() == 0, 2'b00, 5'(exp_q.size())});
  endtask

  // ********************************************************************
  // window model, stepped with the levels the DUT samples this edge.
  // ********************************************************************
  function automatic corr_byte_t saturate(input int c);
    saturate = (c > 255) ? 8'hff : corr_byte_t'(c);
  endfunction

  task automatic close_window();
    last_x  = saturate(m_cx);
    last_y  = saturate(m_cy);
    last_xy = saturate(m_cxy);
    if (exp_q.size() + `CORR_PKT_LEN <= `CORR_FIFO_DEPTH) begin
      exp_q.push_back(last_x);
      exp_q.push_back(last_y);
      exp_q.push_back(last_xy);
      exp_q.push_back(corr_byte_t'(m_seq));
    end
    m_seq = (m_seq + 1) % 256;
    win_count++;
    m_smp = 0;
    m_cx  = 0;
    m_cy  = 0;
    m_cxy = 0;
  endtask

  task automatic model_step();
    if (i_cg) begin
      if (m_per == 0) begin
        m_cx  += int'(i_x);
        m_cy  += int'(i_y);
        m_cxy += int'(i_x & i_y);
        m_smp++;
        if (m_smp == (1 << cfg_win)) close_window();
      end
      m_per = (m_per + 1) % (1 << cfg_per);
    end
  endtask

  task automatic run_windows(input int n_win);
    int   goal;
    int   n;
    logic bx, by, bc0, bc1;
    goal = win_count + n_win;
    for (n = 0; n < RUN_LIMIT && win_count < goal; n++) begin
      @(posedge i_clk);
      model_step();
      rand_bit(bx);
      rand_bit(by);
      rand_bit(bc0);
      rand_bit(bc1);
      i_x  <= bx | x_high;
      i_y  <= by;
      i_cg <= (win_count < goal) && !(cg_drop && bc0 && bc1); // about one drop in four.
    end
    if (win_count < goal) abort_run("timeout, the sample windows did not finish");
  endtask

  // the last packet takes CORR_PKT_LEN cycles to reach the fifo.
  task automatic settle();
    repeat (`CORR_PKT_LEN + 2) @(posedge i_clk);
  endtask

  task automatic check_pwm(input logic [1:0] src);
    corr_byte_t metric;
    int         highs;
    int         n;
    case (src)
      2'd0:    metric = last_x;
      2'd1:    metric = last_y;
      default: metric = last_xy;
    endcase
    highs = 0;
    for (n = 0; n < 256; n++) begin
      @(negedge i_clk);
      highs += int'(o_led);
    end
    check_value("o_led high cycles", highs, metric);
  endtask

  task automatic check_registers();
    corr_byte_t got;
    @(negedge i_clk);
    check_value("o_up_ready", o_up_ready, 1);
    check_value("o_dn_valid", o_dn_valid, 0);
    check_value("o_led", o_led, 0);
    write_reg(REG_WIN_EXP, 8'h0c);
    write_reg(REG_PER_EXP, 8'h3f);
    write_reg(REG_LED_SRC, 8'h02);
    write_reg(REG_FIFO_STAT, 8'h55); // read-only.
    read_reg(REG_WIN_EXP, got);
    check_value("o_dn_data (win_exp)", got, `CORR_MAX_WIN_EXP);
    read_reg(REG_PER_EXP, got);
    check_value("o_dn_data (per_exp)", got, `CORR_MAX_PER_EXP);
    read_reg(REG_LED_SRC, got);
    check_value("o_dn_data (led_src)", got, 2);
    read_reg(3'd6, got);
    check_value("o_dn_data (unused address)", got, 0);
    check_status();
    read_fifo_byte();
  endtask

  task automatic configure(input row_t row);
    corr_byte_t got;
    write_reg(REG_WIN_EXP, {4'h0, row.win_exp});
    write_reg(REG_PER_EXP, {4'h0, row.per_exp});
    write_reg(REG_LED_SRC, {6'h00, row.led_src});
    write_reg(REG_FLUSH, 8'h00);
    read_reg(REG_WIN_EXP, got);
    check_value("o_dn_data (win_exp)", got, row.win_exp);
    read_reg(REG_PER_EXP, got);
    check_value("o_dn_data (per_exp)", got, row.per_exp);
    read_reg(REG_LED_SRC, got);
    check_value("o_dn_data (led_src)", got, row.led_src);
    cfg_win    = int'(row.win_exp);
    cfg_per    = int'(row.per_exp);
    m_per      = 0;
    m_smp      = 0;
    m_cx       = 0;
    m_cy       = 0;
    m_cxy      = 0;
    m_seq      = 0;
    win_count  = 0;
    exp_q.delete();
    check_status();
  endtask

  task automatic run_row(input row_t row);
    stall_on = row.stall;
    cg_drop  = row.cg_drop;
    x_high   = row.x_high;
    configure(row);
    run_windows(int'(row.n_win));
    settle();
    check_status();
    check_pwm(row.led_src);
    if (row.overflow) begin
      drain_packets(2);
      run_windows(2);
      settle();
      check_status();
      drain_packets(3); // seq 3 is followed by seq 6.
      write_reg(REG_FLUSH, 8'h00);
      exp_q.delete();
      check_status();
    end else begin
      drain_packets(exp_q.size() / `CORR_PKT_LEN);
      read_fifo_byte();
    end
  endtask

  initial begin
    int r;
    i_clk      = 1'b0;
    i_arst_n   = 1'b0;
    i_cg       = 1'b0;
    i_x        = 1'b0;
    i_y        = 1'b0;
    i_up_data  = '0;
    i_up_valid = 1'b0;
    i_dn_ready = 1'b1;
    lfsr_q     = 32'hb9fa_89f9;
    stall_on   = 1'b0;
    cg_drop    = 1'b0;
    x_high     = 1'b0;
    // win, per, led src, windows, cg drop, stall, overflow, x held high.
    rows[0] = '{4'd3, 4'd0, 2'd0, 8'd3, 1'b0, 1'b0, 1'b0, 1'b0};
    rows[1] = '{4'd8, 4'd0, 2'd0, 8'd2, 1'b0, 1'b0, 1'b0, 1'b1};
    rows[2] = '{4'd4, 4'd2, 2'd2, 8'd3, 1'b1, 1'b0, 1'b0, 1'b0};
    rows[3] = '{4'd2, 4'd1, 2'd1, 8'd6, 1'b1, 1'b1, 1'b1, 1'b0};
    rows[4] = '{4'd5, 4'd0, 2'd1, 8'd2, 1'b0, 1'b1, 1'b0, 1'b0};
    repeat (5) @(posedge i_clk);
    i_arst_n <= 1'b1;
    check_registers();
    for (r = 0; r < NUM_ROWS; r++) run_row(rows[r]);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire
